// ==== dv/opn_tb_cases.svh ====
//********************
// Case table with register writes,
// wait bounds and expected status and irq_n
//********************
`ifndef OPN_TB_CASES_SVH
`define OPN_TB_CASES_SVH

// Each row holds the name, the write count, four {register, value} writes,
// the status bit and its expected value, min and max wait in cycles,
// hold instead of wait, expected flags B/A, expected irq_n,
// the random write index and its upper bound
// For a random write the wait bounds are offsets to the timer B period
task automatic load_cases();
    add_case("reset", 0, 16'h0, 16'h0, 16'h0, 16'h0,
             STATUS_BUSY_BIT, 1'b0, 0, 0, 1'b0, 2'b00, 1'b1, -1, 0);
    add_case("busy_set", 1, {REG_TA_LO, 8'h00}, 16'h0, 16'h0, 16'h0,
             STATUS_BUSY_BIT, 1'b1, 1, 1, 1'b0, 2'b00, 1'b1, -1, 0);
    add_case("busy_clear", 0, 16'h0, 16'h0, 16'h0, 16'h0,
             STATUS_BUSY_BIT, 1'b0, (BUSY_TICKS - 2) * PRESCALE,
             (BUSY_TICKS + 1) * PRESCALE + 3, 1'b0, 2'b00, 1'b1, -1, 0);
    // Timer A at 1020 in fast mode with its flag enabled
    add_case("ta_fast_flag", 4, {REG_TEST, 8'h04}, {REG_TA_HI, 8'hff},
             {REG_TA_LO, 8'h00}, {REG_TIMER_CTL, 8'h05},
             STATUS_FLAG_A_BIT, 1'b1, 3, 8, 1'b0, 2'b01, 1'b0, -1, 0);
    add_case("ta_clear", 1, {REG_TIMER_CTL, 8'h11}, 16'h0, 16'h0, 16'h0,
             STATUS_FLAG_A_BIT, 1'b0, 0, 4, 1'b0, 2'b00, 1'b1, -1, 0);
    add_case("ta_no_flag", 0, 16'h0, 16'h0, 16'h0, 16'h0,
             STATUS_FLAG_A_BIT, 1'b0, 0, 20, 1'b1, 2'b00, 1'b1, -1, 0);
    // Timer A runs along so that both flags are up for the clear
    add_case("tb_fast", 2, {REG_TB, 8'd250}, {REG_TIMER_CTL, 8'h0f}, 16'h0, 16'h0,
             STATUS_FLAG_B_BIT, 1'b1, -2, 4, 1'b0, 2'b11, 1'b0, 0, 255);
    add_case("flag_clear", 1, {REG_TIMER_CTL, 8'h30}, 16'h0, 16'h0, 16'h0,
             STATUS_FLAG_B_BIT, 1'b0, 0, 4, 1'b0, 2'b00, 1'b1, -1, 0);
    add_case("ta_prescaled", 2, {REG_TEST, 8'h00}, {REG_TIMER_CTL, 8'h05}, 16'h0, 16'h0,
             STATUS_FLAG_A_BIT, 1'b1, 3 * PRESCALE, 4 * PRESCALE + PRESCALE + 4,
             1'b0, 2'b01, 1'b0, -1, 0);
endtask

`endif

// ==== dv/opn_tb.sv ====
//********************
// Testbench for the FM host interface
// Clock, reset, bus tasks, case loop and watchdog
//********************
`timescale 1ns/1ns

module opn_tb import opn_pkg::*; ();

    localparam int CLK_PERIOD = 40;
    localparam int PRESCALE   = 6;
    localparam int BUSY_TICKS = 32;
    localparam int TB_STEP    = 16;     // Timer ticks per timer B step
    localparam int N_CASES    = 9;
    localparam int MARGIN     = 200;    // Spare cycles for the watchdog

    logic       clk;
    logic       rst;
    logic       cen;
    reg_data_t  din;
    logic [1:0] addr;
    logic       cs_n;
    logic       wr_n;
    reg_data_t  dout;
    logic       irq_n;

    // Case table, filled by load_cases
    string       case_name  [N_CASES];
    int          case_nwr   [N_CASES];
    logic [15:0] case_wr    [N_CASES][4];    // {register, value}
    int          case_bit   [N_CASES];
    logic        case_exp   [N_CASES];
    int          case_min   [N_CASES];
    int          case_max   [N_CASES];
    logic        case_hold  [N_CASES];
    logic [1:0]  case_flags [N_CASES];
    logic        case_irq   [N_CASES];
    int          case_rnd   [N_CASES];
    int          case_rnd_hi[N_CASES];
    int          n_loaded;
    int          limit_cycles;
    int          errors;

    opn_bus_top #(
        .PRESCALE   ( PRESCALE   ),
        .BUSY_TICKS ( BUSY_TICKS )
    ) uut (
        .clk   ( clk   ),
        .rst   ( rst   ),
        .cen   ( cen   ),
        .din   ( din   ),
        .addr  ( addr  ),
        .cs_n  ( cs_n  ),
        .wr_n  ( wr_n  ),
        .dout  ( dout  ),
        .irq_n ( irq_n )
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic add_case(input string name, input int nwr,
                            input logic [15:0] w0, w1, w2, w3,
                            input int bit_idx, input logic exp,
                            input int min_wait, max_wait, input logic hold,
                            input logic [1:0] flags, input logic irq,
                            input int rnd_idx, rnd_hi);
        case_name[n_loaded]   = name;
        case_nwr[n_loaded]    = nwr;
        case_wr[n_loaded][0]  = w0;
        case_wr[n_loaded][1]  = w1;
        case_wr[n_loaded][2]  = w2;
        case_wr[n_loaded][3]  = w3;
        case_bit[n_loaded]    = bit_idx;
        case_exp[n_loaded]    = exp;
        case_min[n_loaded]    = min_wait;
        case_max[n_loaded]    = max_wait;
        case_hold[n_loaded]   = hold;
        case_flags[n_loaded]  = flags;
        case_irq[n_loaded]    = irq;
        case_rnd[n_loaded]    = rnd_idx;
        case_rnd_hi[n_loaded] = rnd_hi;
        n_loaded++;
    endtask

    `include "opn_tb_cases.svh"

    // Address phase then data phase, inputs move on the falling edge
    task automatic wr_reg(input reg_addr_t r, input reg_data_t v);
        @(negedge clk);
        cs_n = 1'b0;
        wr_n = 1'b0;
        addr = 2'b00;
        din  = r;
        @(negedge clk);
        addr = 2'b01;
        din  = v;
        @(negedge clk);
        cs_n = 1'b1;
        wr_n = 1'b1;
        addr = 2'b00;
    endtask

    task automatic wait_status(input int bit_idx, input logic exp, input int max_cycles,
                               output int cycles, output logic found);
        cycles = 0;
        found  = (dout[bit_idx] === exp);
        while (!found && cycles < max_cycles) begin
            @(negedge clk);
            cycles++;
            found = (dout[bit_idx] === exp);
        end
    endtask

    // Bit must keep its value for n cycles
    task automatic hold_status(input int bit_idx, input logic exp, input int n,
                               output int bad_cycle, output reg_data_t bad_dout);
        int i;
        bad_cycle = -1;
        bad_dout  = '0;
        for (i = 1; i <= n && bad_cycle < 0; i++) begin
            @(negedge clk);
            if (dout[bit_idx] !== exp) begin
                bad_cycle = i;
                bad_dout  = dout;
            end
        end
    endtask

    initial begin : watchdog
        wait (limit_cycles > 0);
        #(limit_cycles * CLK_PERIOD);
        $display("Timeout: the run did not end within %0d cycles", limit_cycles);
        $display("SIMULATION FAILED");
        $finish;
    end

    initial begin : main
        integer      seed;
        int          t;
        int          w;
        int          cycles;
        int          bad;
        int          base;
        int          lo_b;
        int          hi_b;
        int          budget;
        int          errs_before;
        int          n_pass;
        int          n_fail;
        logic        found;
        logic [31:0] rnd;
        reg_data_t   wval;
        reg_data_t   bad_dout;

        clk          = 1'b0;
        rst          = 1'b1;
        cen          = 1'b1;
        din          = '0;
        addr         = 2'b00;
        cs_n         = 1'b1;
        wr_n         = 1'b1;
        seed         = 32'hbf;
        errors       = 0;
        n_pass       = 0;
        n_fail       = 0;
        n_loaded     = 0;
        limit_cycles = 0;
        load_cases();

        // Worst case length of every row
        budget = 16 + MARGIN;
        for (t = 0; t < n_loaded; t++) begin
            budget += case_nwr[t] * 3 + case_max[t] + 2;
            if (case_rnd[t] >= 0)
                budget += (2 ** $bits(timer_b_t) - case_wr[t][case_rnd[t]][7:0]) * TB_STEP;
        end
        limit_cycles = budget;

        repeat (16) @(negedge clk);
        rst = 1'b0;

        for (t = 0; t < n_loaded; t++) begin
            errs_before = errors;
            base        = 0;
            for (w = 0; w < case_nwr[t]; w++) begin
                wval = case_wr[t][w][7:0];
                if (w == case_rnd[t]) begin
                    rnd  = $random(seed);
                    wval = reg_data_t'(wval + rnd % (case_rnd_hi[t] - wval + 1));
                    base = (2 ** $bits(timer_b_t) - wval) * TB_STEP;    // Overflow period
                end
                wr_reg(case_wr[t][w][15:8], wval);
            end
            lo_b = base + case_min[t];
            hi_b = base + case_max[t];

            if (case_hold[t]) begin
                hold_status(case_bit[t], case_exp[t], hi_b, bad, bad_dout);
                if (bad >= 0) begin
                    $display("FAIL %s: dout = 0x%h at cycle %0d, bit %0d expected 0x%h",
                             case_name[t], bad_dout, bad, case_bit[t], case_exp[t]);
                    errors++;
                end
                cycles = hi_b;
            end else begin
                wait_status(case_bit[t], case_exp[t], hi_b, cycles, found);
                if (!found) begin
                    $display("%s: status bit %0d did not reach %0d within %0d cycles",
                             case_name[t], case_bit[t], case_exp[t], hi_b);
                    errors++;
                end else if (cycles < lo_b) begin
                    $display("%s: status bit %0d changed after %0d cycles, before %0d",
                             case_name[t], case_bit[t], cycles, lo_b);
                    errors++;
                end
            end

            if (dout[1:0] !== case_flags[t]) begin
                $display("FAIL %s: dout[1:0] = 0x%h, expected 0x%h",
                         case_name[t], dout[1:0], case_flags[t]);
                errors++;
            end
            if (dout[6:2] !== 5'h00) begin
                $display("FAIL %s: dout[6:2] = 0x%h, expected 0x00", case_name[t], dout[6:2]);
                errors++;
            end
            if (irq_n !== case_irq[t]) begin
                $display("FAIL %s: irq_n = 0x%h, expected 0x%h",
                         case_name[t], irq_n, case_irq[t]);
                errors++;
            end

            if (errors == errs_before) begin
                n_pass++;
                $display("%s passed after %0d cycles", case_name[t], cycles);
            end else begin
                n_fail++;
                $display("%s failed", case_name[t]);
            end
        end

        $display("%0d tests run, %0d passed, %0d failed, %0d errors",
                 n_loaded, n_pass, n_fail, errors);
        if (errors == 0)
            $display("SIMULATION PASSED");
        else
            $display("SIMULATION FAILED");
        $finish;
    end

endmodule

// ==== hdl/opn_bus_top.sv ====
//********************
// Host side of the FM chip
//********************
`timescale 1ns/1ns

module opn_bus_top import opn_pkg::*; #(
    parameter int PRESCALE   = 6,     // cen pulses per internal tick
    parameter int BUSY_TICKS = 32     // Busy length in internal ticks
) (
    input  logic       clk,
    input  logic       rst,
    input  logic       cen,       // Clock enable, tie high if unused
    input  reg_data_t  din,
    input  logic [1:0] addr,
    input  logic       cs_n,
    input  logic       wr_n,
    output reg_data_t  dout,      // Status byte
    output logic       irq_n
);

    logic tick_en;

    timer_cfg_if cfg ();

    // Internal tick shared by busy and the timers
    opn_clk_div #(
        .PRESCALE ( PRESCALE )
    ) u_clk_div (
        .clk     ( clk     ),
        .rst     ( rst     ),
        .cen     ( cen     ),
        .tick_en ( tick_en )
    );

    opn_regs #(
        .BUSY_TICKS ( BUSY_TICKS )
    ) u_regs (
        .clk     ( clk     ),
        .rst     ( rst     ),
        .tick_en ( tick_en ),
        .din     ( din     ),
        .addr    ( addr    ),
        .cs_n    ( cs_n    ),
        .wr_n    ( wr_n    ),
        .dout    ( dout    ),
        .cfg     ( cfg     )
    );

    opn_timers u_timers (
        .clk     ( clk     ),
        .rst     ( rst     ),
        .cen     ( cen     ),
        .tick_en ( tick_en ),
        .cfg     ( cfg     ),
        .irq_n   ( irq_n   )
    );

endmodule

// ==== hdl/opn_clk_div.sv ====
//********************
// Prescaler from cen to the internal tick
//********************
`timescale 1ns/1ns

module opn_clk_div #(
    parameter int PRESCALE = 6
) (
    input  logic clk,
    input  logic rst,
    input  logic cen,
    output logic tick_en
);

    localparam int CW = (PRESCALE > 1) ? $clog2(PRESCALE) : 1;

    logic [CW-1:0] cen_cnt;
    logic          last;

    assign last = (cen_cnt == CW'(PRESCALE - 1));

    // Count cen pulses, tick on the last one of each group
    always_ff @(posedge clk) begin
        if (rst) begin
            cen_cnt <= '0;
            tick_en <= 1'b0;    // No tick during reset
        end else begin
            tick_en <= cen & last;
            if (cen) begin
                if (last)
                    cen_cnt <= '0;
                else
                    cen_cnt <= cen_cnt + 1'b1;
            end
        end
    end

endmodule

// ==== hdl/opn_pkg.sv ====
//********************
// Register map, field widths and status
// bit positions of the FM host interface
//********************
package opn_pkg;

    typedef logic [7:0] reg_addr_t;    // Register number
    typedef logic [7:0] reg_data_t;    // Bus data
    typedef logic [9:0] timer_a_t;     // Timer A count and load value
    typedef logic [7:0] timer_b_t;     // Timer B count and load value

    // Timer registers, bank 0
    localparam reg_addr_t REG_TEST      = 8'h21;
    localparam reg_addr_t REG_TA_HI     = 8'h24;
    localparam reg_addr_t REG_TA_LO     = 8'h25;
    localparam reg_addr_t REG_TB        = 8'h26;
    localparam reg_addr_t REG_TIMER_CTL = 8'h27;

    localparam int TA_LO_W = 2;    // Timer A bits held in REG_TA_LO

    // Test register
    localparam int FAST_TIMERS_BIT = 2;

    // Timer control register
    localparam int LOAD_A_BIT     = 0;
    localparam int LOAD_B_BIT     = 1;
    localparam int EN_FLAG_A_BIT  = 2;
    localparam int EN_FLAG_B_BIT  = 3;
    localparam int CLR_FLAG_A_BIT = 4;
    localparam int CLR_FLAG_B_BIT = 5;

    // Status byte, other bits read 0
    localparam int STATUS_BUSY_BIT   = 7;
    localparam int STATUS_FLAG_B_BIT = 1;
    localparam int STATUS_FLAG_A_BIT = 0;

endpackage

// ==== hdl/opn_regs.sv ====
//********************
// Address latch, register decode,
// busy counter and status read
//********************
`timescale 1ns/1ns

module opn_regs import opn_pkg::*; #(
    parameter int BUSY_TICKS = 32
) (
    input  logic       clk,
    input  logic       rst,
    input  logic       tick_en,
    input  reg_data_t  din,
    input  logic [1:0] addr,
    input  logic       cs_n,
    input  logic       wr_n,
    output reg_data_t  dout,
    timer_cfg_if.regs  cfg
);

    localparam int BUSY_W = $clog2(BUSY_TICKS + 1);

    logic              write;
    logic              addr_wr;
    logic              data_wr;
    reg_addr_t         sel_reg;     // Latched register number
    logic              sel_hi;      // Upper bank selected
    logic [BUSY_W-1:0] busy_cnt;
    logic              busy;
    reg_data_t         status;

    assign write   = ~cs_n & ~wr_n;
    assign addr_wr = write & ~addr[0];
    assign data_wr = write & addr[0];

    // Register number from an address write
    always_ff @(posedge clk) begin
        if (rst) begin
            sel_reg <= '0;
            sel_hi  <= 1'b0;
        end else if (addr_wr) begin
            sel_reg <= din;
            sel_hi  <= addr[1];    // Timers only live in bank 0
        end
    end

    // Data write decode
    always_ff @(posedge clk) begin
        if (rst) begin
            cfg.value_a     <= '0;
            cfg.value_b     <= '0;
            cfg.load_a      <= 1'b0;
            cfg.load_b      <= 1'b0;
            cfg.en_flag_a   <= 1'b0;
            cfg.en_flag_b   <= 1'b0;
            cfg.clr_flag_a  <= 1'b0;
            cfg.clr_flag_b  <= 1'b0;
            cfg.fast_timers <= 1'b0;
        end else begin
            cfg.clr_flag_a <= 1'b0;    // Clear pulses last one clk
            cfg.clr_flag_b <= 1'b0;
            if (data_wr && !sel_hi) begin
                case (sel_reg)
                    REG_TEST:
                        cfg.fast_timers <= din[FAST_TIMERS_BIT];
                    REG_TA_HI:
                        cfg.value_a[TA_LO_W +: $bits(reg_data_t)] <= din;
                    REG_TA_LO:
                        cfg.value_a[TA_LO_W-1:0] <= din[TA_LO_W-1:0];
                    REG_TB:
                        cfg.value_b <= din;
                    REG_TIMER_CTL: begin
                        cfg.load_a     <= din[LOAD_A_BIT];
                        cfg.load_b     <= din[LOAD_B_BIT];
                        cfg.en_flag_a  <= din[EN_FLAG_A_BIT];
                        cfg.en_flag_b  <= din[EN_FLAG_B_BIT];
                        cfg.clr_flag_a <= din[CLR_FLAG_A_BIT];
                        cfg.clr_flag_b <= din[CLR_FLAG_B_BIT];
                    end
                    default: ;    // Sound registers are not kept
                endcase
            end
        end
    end

    // Busy runs for BUSY_TICKS internal ticks after every data write,
    // a new write restarts the count
    always_ff @(posedge clk) begin
        if (rst)
            busy_cnt <= '0;
        else if (data_wr)
            busy_cnt <= BUSY_W'(BUSY_TICKS);
        else if (tick_en && busy)
            busy_cnt <= busy_cnt - 1'b1;
    end

    assign busy = (busy_cnt != '0);

    always_comb begin
        status                    = '0;
        status[STATUS_BUSY_BIT]   = busy;
        status[STATUS_FLAG_B_BIT] = cfg.flag_b;
        status[STATUS_FLAG_A_BIT] = cfg.flag_a;
    end

    // Status is read with no strobe
    always_ff @(posedge clk) begin
        if (rst)
            dout <= '0;
        else
            dout <= status;
    end

endmodule

// ==== hdl/opn_timer.sv ====
//********************
// One timer with sub-divider,
// reload and sticky flag
//********************
`timescale 1ns/1ns

module opn_timer #(
    parameter int CNT_W = 10,
    parameter int MULT  = 1
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             tick,
    input  logic [CNT_W-1:0] value,
    input  logic             load,
    input  logic             en_flag,
    input  logic             clr_flag,
    output logic             flag
);

    localparam int DIV_W = (MULT > 1) ? $clog2(MULT) : 1;

    logic [DIV_W-1:0] div_cnt;
    logic [CNT_W-1:0] cnt;
    logic             step;        // Counter advances
    logic             overflow;

    assign step     = load & tick & (div_cnt == DIV_W'(MULT - 1));
    assign overflow = step & (cnt == '1);

    // Sub-divider restarts whenever the timer is stopped
    always_ff @(posedge clk) begin
        if (rst || !load) begin
            div_cnt <= '0;
        end else if (tick) begin
            if (step)
                div_cnt <= '0;
            else
                div_cnt <= div_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst)
            cnt <= '0;
        else if (!load)
            cnt <= value;           // Held at the load value
        else if (overflow)
            cnt <= value;           // Reload
        else if (step)
            cnt <= cnt + 1'b1;
    end

    // Flag stays up until cleared
    always_ff @(posedge clk) begin
        if (rst)
            flag <= 1'b0;
        else if (clr_flag)
            flag <= 1'b0;
        else if (overflow && en_flag)
            flag <= 1'b1;
    end

endmodule

// ==== hdl/opn_timers.sv ====
//********************
// Timer A and timer B, tick select
// and the interrupt output
//********************
`timescale 1ns/1ns

module opn_timers import opn_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        cen,
    input  logic        tick_en,
    timer_cfg_if.timers cfg,
    output logic        irq_n
);

    localparam int TB_MULT = 16;    // Timer B steps every 16th tick

    logic timer_tick;

    // Test mode runs both timers straight from cen
    assign timer_tick = cfg.fast_timers ? cen : tick_en;

    opn_timer #(
        .CNT_W ( $bits(timer_a_t) ),
        .MULT  ( 1                )
    ) u_timer_a (
        .clk      ( clk            ),
        .rst      ( rst            ),
        .tick     ( timer_tick     ),
        .value    ( cfg.value_a    ),
        .load     ( cfg.load_a     ),
        .en_flag  ( cfg.en_flag_a  ),
        .clr_flag ( cfg.clr_flag_a ),
        .flag     ( cfg.flag_a     )
    );

    opn_timer #(
        .CNT_W ( $bits(timer_b_t) ),
        .MULT  ( TB_MULT          )
    ) u_timer_b (
        .clk      ( clk            ),
        .rst      ( rst            ),
        .tick     ( timer_tick     ),
        .value    ( cfg.value_b    ),
        .load     ( cfg.load_b     ),
        .en_flag  ( cfg.en_flag_b  ),
        .clr_flag ( cfg.clr_flag_b ),
        .flag     ( cfg.flag_b     )
    );

    always_ff @(posedge clk) begin
        if (rst)
            irq_n <= 1'b1;
        else
            irq_n <= ~(cfg.flag_a | cfg.flag_b);    // Low while any flag is set
    end

endmodule

// ==== hdl/timer_cfg_if.sv ====
//********************
// Timer settings and flags between
// the register block and the timers
//********************
`timescale 1ns/1ns

interface timer_cfg_if import opn_pkg::*; ();

    timer_a_t value_a;
    timer_b_t value_b;
    logic     load_a;         // Timer runs while high
    logic     load_b;
    logic     en_flag_a;
    logic     en_flag_b;
    logic     clr_flag_a;     // One clk pulse
    logic     clr_flag_b;
    logic     fast_timers;    // Test mode, timers tick on cen
    logic     flag_a;
    logic     flag_b;

    modport regs (
        output value_a, value_b,
        output load_a, load_b,
        output en_flag_a, en_flag_b,
        output clr_flag_a, clr_flag_b,
        output fast_timers,
        input  flag_a, flag_b
    );

    modport timers (
        input  value_a, value_b,
        input  load_a, load_b,
        input  en_flag_a, en_flag_b,
        input  clr_flag_a, clr_flag_b,
        input  fast_timers,
        output flag_a, flag_b
    );

endinterface

// ==== vlog.f ====
+incdir+dv
hdl/opn_pkg.sv
hdl/timer_cfg_if.sv
hdl/opn_clk_div.sv
hdl/opn_regs.sv
hdl/opn_timer.sv
hdl/opn_timers.sv
hdl/opn_bus_top.sv
dv/opn_tb.sv
